//--- rtl/ring_pkg.sv
/* Widths, beat structs and opcodes shared by the staging ring and its testbench.
   CNT_W must hold LANES; a beat never carries more than LANES words */
package ring_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  // Bits per data word
  localparam int DATA_W = 8;
  // Most words moved per cycle, on either side
  localparam int LANES = 2;
  // Beat count, 0 to LANES
  localparam int CNT_W = 2;

  // Producer command, at most one per cycle
  typedef enum logic [1:0] {
    CMD_NONE   = 2'd0,
    CMD_COMMIT = 2'd1,
    CMD_ABORT  = 2'd2,
    CMD_FLUSH  = 2'd3
  } cmd_e;

  // Packet state of the producer side
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_OPEN = 2'd1,
    ST_DROP = 2'd2   // packet lost, beats ignored until commit or abort
  } pkt_state_e;

  // ------------------------------
  // Beat structs
  // ------------------------------
  // Write beat, lane 0 is the older word
  typedef struct packed {
    logic                         valid;
    logic [CNT_W-1:0]             count;
    logic [LANES-1:0][DATA_W-1:0] data;
  } wr_beat_t;

  // Pop request
  typedef struct packed {
    logic             valid;
    logic [CNT_W-1:0] count;
  } rd_req_t;

  // Pop response, one cycle after the request
  typedef struct packed {
    logic                         valid;
    logic [CNT_W-1:0]             count;
    logic [LANES-1:0][DATA_W-1:0] data;
  } rd_resp_t;

endpackage

//--- rtl/counter_incr.sv
/* Wraps at MaxValue even when MaxValue+1 is not a power of two.
   ValueWidth must equal $clog2(MaxValue+1), and LANES must not exceed MaxValue */
`timescale 1ns/1ps

module counter_incr #(
  parameter int ValueWidth          = 4,
  parameter int MaxValue            = 11,
  parameter bit EnableReinitAndIncr = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       reinit,
  input  logic [ValueWidth-1:0]      initial_value,
  input  logic                       incr_valid,
  input  logic [ring_pkg::CNT_W-1:0] incr,
  output logic [ValueWidth-1:0]      value,
  output logic [ValueWidth-1:0]      value_next
);

  // One spare bit holds value + incr before the wrap
  localparam int TempWidth  = ValueWidth + 1;
  localparam int MaxValueP1 = MaxValue + 1;
  localparam bit IsPow2     = (MaxValueP1 & (MaxValueP1 - 1)) == 0;

  logic [TempWidth-1:0] incr_ext;
  logic [TempWidth-1:0] value_temp;

  // Zero when there is no step this cycle
  assign incr_ext = incr_valid ? TempWidth'(incr) : '0;

  // ------------------------------
  // Sum before wrap
  // ------------------------------
  if (EnableReinitAndIncr) begin : gen_reinit_and_incr
    // Step lands on top of the loaded value
    assign value_temp = (reinit ? TempWidth'(initial_value) : TempWidth'(value)) + incr_ext;
  end else begin : gen_reinit_only
    // Reinit wins, the step is dropped
    assign value_temp = reinit ? TempWidth'(initial_value) : TempWidth'(value) + incr_ext;
  end

  // ------------------------------
  // Wrap
  // ------------------------------
  if (IsPow2) begin : gen_pow2_wrap
    // Carry out of the top bit is the wrap
    assign value_next = value_temp[ValueWidth-1:0];
  end else begin : gen_mod_wrap
    logic [TempWidth-1:0] value_wrapped;

    // Remainder past MaxValue, at most one lap since incr <= MaxValue
    assign value_wrapped = value_temp - TempWidth'(MaxValueP1);
    assign value_next    = (value_temp > TempWidth'(MaxValue)) ?
                           value_wrapped[ValueWidth-1:0] : value_temp[ValueWidth-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (incr_valid || reinit) begin
      value <= value_next;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // Callers never step past one full beat
  incr_in_range_a : assert property (@(posedge clk) disable iff (!rst_n)
    incr_valid |-> int'(incr) <= ring_pkg::LANES);

  value_in_range_a : assert property (@(posedge clk) disable iff (!rst_n)
    int'(value) <= MaxValue);

  // What was announced as next is what the register holds
  value_follows_next_a : assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> value == $past(value_next));

endmodule

//--- rtl/ring_ctrl.sv
/* Packet FSM; strobes are combinational from state and command.
   Abort outranks a same-cycle beat, and a dropped packet commits nothing */
`timescale 1ns/1ps

module ring_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  ring_pkg::cmd_e cmd,
  input  logic           beat_valid,
  input  logic           beat_fits,
  output logic           wr_accept,
  output logic           commit_en,
  output logic           rewind,
  output logic           flush_en,
  output logic           overflow
);

  ring_pkg::pkt_state_e state;
  ring_pkg::pkt_state_e state_next;
  // Producer may still add to the packet
  logic in_pkt;
  // Commit or abort ends the packet
  logic closing;
  logic is_abort;

  assign in_pkt   = (state != ring_pkg::ST_DROP);
  assign is_abort = (cmd == ring_pkg::CMD_ABORT);
  assign closing  = (cmd == ring_pkg::CMD_COMMIT) || is_abort;

  // ------------------------------
  // Strobes
  // ------------------------------
  // Aborted beat is thrown away anyway, so it never overflows
  assign overflow  = in_pkt && beat_valid && !beat_fits && !is_abort;
  assign wr_accept = in_pkt && beat_valid && beat_fits && !is_abort;
  // Commit alongside an overflowing beat closes an empty packet
  assign commit_en = in_pkt && (cmd == ring_pkg::CMD_COMMIT) && !overflow;
  // Both abort and drop return the write pointer to the commit point
  assign rewind    = overflow || (in_pkt && is_abort);
  // Flush is independent of the packet state
  assign flush_en  = (cmd == ring_pkg::CMD_FLUSH);

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ring_pkg::ST_IDLE, ring_pkg::ST_OPEN: begin
        if (closing) begin
          state_next = ring_pkg::ST_IDLE;
        end else if (overflow) begin
          state_next = ring_pkg::ST_DROP;
        end else if (beat_valid) begin
          state_next = ring_pkg::ST_OPEN;
        end
      end
      ring_pkg::ST_DROP: begin
        if (closing) begin
          state_next = ring_pkg::ST_IDLE;
        end
      end
      default: state_next = ring_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ring_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Once dropped, nothing more of the packet is written or reported
  drop_holds_a : assert property (@(posedge clk) disable iff (!rst_n)
    overflow && !closing |=> !wr_accept && !overflow);

  no_commit_on_drop_a : assert property (@(posedge clk) disable iff (!rst_n)
    overflow |-> !commit_en);

endmodule

//--- rtl/ring_ptrs.sv
/* Write, read and commit pointers of a Depth-slot ring; one slot stays empty.
   Depth must be at least 4 so that a pointer is as wide as a beat count */
`timescale 1ns/1ps

module ring_ptrs #(
  parameter  int Depth    = 12,
  localparam int PtrWidth = $clog2(Depth)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [ring_pkg::CNT_W-1:0] wr_count,
  input  logic                       wr_accept,
  input  logic                       commit_en,
  input  logic                       rewind,
  input  logic                       flush_en,
  input  ring_pkg::rd_req_t          rd,
  output logic                       beat_fits,
  output logic [PtrWidth-1:0]        wr_addr,
  output logic [ring_pkg::CNT_W-1:0] wr_lanes,
  output logic [PtrWidth-1:0]        rd_addr,
  output logic [ring_pkg::CNT_W-1:0] rd_grant,
  output logic [PtrWidth-1:0]        avail
);

  logic [PtrWidth-1:0] wr_ptr;
  logic [PtrWidth-1:0] wr_ptr_next;
  logic [PtrWidth-1:0] rd_ptr;
  logic [PtrWidth-1:0] commit_ptr;
  logic [PtrWidth-1:0] used;
  logic [PtrWidth-1:0] free_cnt;

  // Forward distance from one pointer to another, modulo Depth
  function automatic logic [PtrWidth-1:0] ring_dist(input logic [PtrWidth-1:0] from_ptr,
                                                    input logic [PtrWidth-1:0] to_ptr);
    logic [PtrWidth:0] span;
    span = {1'b0, to_ptr} - {1'b0, from_ptr};
    if (to_ptr < from_ptr) begin
      span = span + (PtrWidth + 1)'(Depth);
    end
    return span[PtrWidth-1:0];
  endfunction

  // ------------------------------
  // Pointers
  // ------------------------------
  // Abort or drop lands back on the commit point, same-cycle beat lost
  counter_incr #(
    .ValueWidth         (PtrWidth),
    .MaxValue           (Depth - 1),
    .EnableReinitAndIncr(1'b0)
  ) wr_cnt_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .reinit       (rewind),
    .initial_value(commit_ptr),
    .incr_valid   (wr_accept),
    .incr         (wr_count),
    .value        (wr_ptr),
    .value_next   (wr_ptr_next)
  );

  // Flush jumps to the commit point, grant is forced to 0 that cycle
  counter_incr #(
    .ValueWidth         (PtrWidth),
    .MaxValue           (Depth - 1),
    .EnableReinitAndIncr(1'b0)
  ) rd_cnt_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .reinit       (flush_en),
    .initial_value(commit_ptr),
    .incr_valid   (rd_grant != '0),
    .incr         (rd_grant),
    .value        (rd_ptr),
    .value_next   ()
  );

  // Commit point includes a beat written in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_ptr <= '0;
    end else if (commit_en) begin
      commit_ptr <= wr_ptr_next;
    end
  end

  // ------------------------------
  // Occupancy and grants
  // ------------------------------
  assign used      = ring_dist(rd_ptr, wr_ptr);
  assign free_cnt  = PtrWidth'(Depth - 1) - used;
  // Only committed words are visible to the consumer
  assign avail     = ring_dist(rd_ptr, commit_ptr);
  assign beat_fits = PtrWidth'(wr_count) <= free_cnt;

  assign wr_addr  = wr_ptr;
  assign wr_lanes = wr_accept ? wr_count : '0;
  assign rd_addr  = rd_ptr;

  // Lesser of request and avail
  always_comb begin
    if (!rd.valid || flush_en) begin
      rd_grant = '0;
    end else if (PtrWidth'(rd.count) > avail) begin
      rd_grant = avail[ring_pkg::CNT_W-1:0];
    end else begin
      rd_grant = rd.count;
    end
  end

  used_in_range_a : assert property (@(posedge clk) disable iff (!rst_n)
    int'(used) <= Depth - 1);

  // Commit point sits between read and write pointers
  commit_inside_a : assert property (@(posedge clk) disable iff (!rst_n)
    avail <= used);

endmodule

//--- rtl/ring_store.sv
/* Depth-word array, two write lanes and two registered read lanes.
   Data and count carry no reset; only the response valid bit is cleared */
`timescale 1ns/1ps

module ring_store #(
  parameter  int Depth    = 12,
  localparam int PtrWidth = $clog2(Depth)
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [PtrWidth-1:0]                             wr_addr,
  input  logic [ring_pkg::CNT_W-1:0]                      wr_lanes,
  input  logic [ring_pkg::LANES-1:0][ring_pkg::DATA_W-1:0] wr_data,
  input  logic [PtrWidth-1:0]                             rd_addr,
  input  logic [ring_pkg::CNT_W-1:0]                      rd_grant,
  output ring_pkg::rd_resp_t                              rd_resp
);

  logic [ring_pkg::DATA_W-1:0] mem [Depth];

  // Lane 1 addresses, wrapped past Depth-1
  logic [PtrWidth-1:0] wr_addr_l1;
  logic [PtrWidth-1:0] rd_addr_l1;

  logic                                            resp_valid;
  logic [ring_pkg::CNT_W-1:0]                      resp_count;
  logic [ring_pkg::LANES-1:0][ring_pkg::DATA_W-1:0] resp_data;

  function automatic logic [PtrWidth-1:0] addr_inc(input logic [PtrWidth-1:0] addr);
    if (addr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return addr + 1'b1;
  endfunction

  assign wr_addr_l1 = addr_inc(wr_addr);
  assign rd_addr_l1 = addr_inc(rd_addr);

  // ------------------------------
  // Write, lane 0 first
  // ------------------------------
  always_ff @(posedge clk) begin
    if (wr_lanes != '0) begin
      mem[wr_addr] <= wr_data[0];
    end
    if (int'(wr_lanes) > 1) begin
      mem[wr_addr_l1] <= wr_data[1];
    end
  end

  // ------------------------------
  // Read
  // ------------------------------
  // Both lanes read every cycle, count tells which matter
  always_ff @(posedge clk) begin
    resp_data[0] <= mem[rd_addr];
    resp_data[1] <= mem[rd_addr_l1];
    resp_count   <= rd_grant;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= (rd_grant != '0);
    end
  end

  assign rd_resp.valid = resp_valid;
  assign rd_resp.count = resp_count;
  assign rd_resp.data  = resp_data;

endmodule

//--- rtl/ring_top.sv
/* Packet staging ring, no back-pressure; beats that do not fit drop the packet.
   Usable capacity is Depth-1 words */
`timescale 1ns/1ps

module ring_top #(
  parameter  int Depth    = 12,
  localparam int PtrWidth = $clog2(Depth)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  ring_pkg::wr_beat_t  wr,
  input  ring_pkg::cmd_e      cmd,
  input  ring_pkg::rd_req_t   rd,
  output ring_pkg::rd_resp_t  rd_resp,
  output logic [PtrWidth-1:0] avail,
  output logic                overflow
);

  // FSM and pointer handshake
  logic beat_fits;
  logic wr_accept;
  logic commit_en;
  logic rewind;
  logic flush_en;

  // Pointer to storage
  logic [PtrWidth-1:0]        wr_addr;
  logic [PtrWidth-1:0]        rd_addr;
  logic [ring_pkg::CNT_W-1:0] wr_lanes;
  logic [ring_pkg::CNT_W-1:0] rd_grant;

  ring_ctrl ring_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .beat_valid(wr.valid),
    .beat_fits (beat_fits),
    .wr_accept (wr_accept),
    .commit_en (commit_en),
    .rewind    (rewind),
    .flush_en  (flush_en),
    .overflow  (overflow)
  );

  ring_ptrs #(
    .Depth(Depth)
  ) ring_ptrs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_count (wr.count),
    .wr_accept(wr_accept),
    .commit_en(commit_en),
    .rewind   (rewind),
    .flush_en (flush_en),
    .rd       (rd),
    .beat_fits(beat_fits),
    .wr_addr  (wr_addr),
    .wr_lanes (wr_lanes),
    .rd_addr  (rd_addr),
    .rd_grant (rd_grant),
    .avail    (avail)
  );

  ring_store #(
    .Depth(Depth)
  ) ring_store_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_addr (wr_addr),
    .wr_lanes(wr_lanes),
    .wr_data (wr.data),
    .rd_addr (rd_addr),
    .rd_grant(rd_grant),
    .rd_resp (rd_resp)
  );

endmodule

//--- tb/tb_ring.sv
/* Random packet traffic against a queue model, Depth 12 so the pointers wrap off a power of two.
   Expected values change on the clock edge and assertions compare them at the next edge */
`timescale 1ns/1ps

module tb_ring;

  localparam int DEPTH        = 12;
  localparam int PTR_W        = $clog2(DEPTH);
  localparam int CNT_W        = ring_pkg::CNT_W;
  localparam int DATA_W       = ring_pkg::DATA_W;
  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 8;
  // Upper bound on the directed part
  localparam int DIR_CYCLES   = 64;
  localparam int PHASE_CYCLES = 800;
  localparam int TIMEOUT_NS   = (RST_CYCLES + DIR_CYCLES + 3 * PHASE_CYCLES + 8) * CLK_PERIOD
                                + 400;

  logic               clk;
  logic               rst_n;
  ring_pkg::wr_beat_t wr;
  ring_pkg::cmd_e     cmd;
  ring_pkg::rd_req_t  rd;
  ring_pkg::rd_resp_t rd_resp;
  logic [PTR_W-1:0]   avail;
  logic               overflow;

  // ------------------------------
  // Reference model
  // ------------------------------
  logic [DATA_W-1:0]    committed_q[$];
  logic [DATA_W-1:0]    pending_q[$];
  ring_pkg::pkt_state_e st_model;
  // Committed plus pending words, what the write side sees as used
  int                   used_model;

  logic                                   exp_valid;
  logic [CNT_W-1:0]                       exp_count;
  logic [ring_pkg::LANES-1:0][DATA_W-1:0] exp_data;
  logic [PTR_W-1:0]                       exp_avail;
  logic                                   exp_overflow;

  int errors;
  int drops;
  int words_read;

  ring_top #(
    .Depth(DEPTH)
  ) ring_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .cmd     (cmd),
    .rd      (rd),
    .rd_resp (rd_resp),
    .avail   (avail),
    .overflow(overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Valid beat in an open or idle packet that needs more than the free slots
  function automatic bit predict_drop(input ring_pkg::pkt_state_e st, input int used,
                                      input ring_pkg::wr_beat_t beat, input ring_pkg::cmd_e c);
    return (st != ring_pkg::ST_DROP) && beat.valid && (c != ring_pkg::CMD_ABORT) &&
           (used + int'(beat.count) > DEPTH - 1);
  endfunction

  assign exp_overflow = predict_drop(st_model, used_model, wr, cmd);

  always @(posedge clk or negedge rst_n) begin : model_update
    int grant;
    bit ovf;
    bit in_pkt;
    bit is_abort;
    if (!rst_n) begin
      committed_q.delete();
      pending_q.delete();
      st_model   = ring_pkg::ST_IDLE;
      used_model = 0;
      exp_valid  = 1'b0;
      exp_count  = '0;
      exp_data   = '0;
      exp_avail  = '0;
    end else begin
      in_pkt   = (st_model != ring_pkg::ST_DROP);
      is_abort = (cmd == ring_pkg::CMD_ABORT);
      ovf      = predict_drop(st_model, committed_q.size() + pending_q.size(), wr, cmd);
      // Pop side sees only what was committed before this edge
      grant = 0;
      if (rd.valid && cmd != ring_pkg::CMD_FLUSH) begin
        grant = (int'(rd.count) < committed_q.size()) ? int'(rd.count) : committed_q.size();
      end
      exp_valid = (grant != 0);
      exp_count = CNT_W'(grant);
      for (int i = 0; i < grant; i++) begin
        exp_data[i] = committed_q.pop_front();
      end
      words_read += grant;
      if (in_pkt && wr.valid && !is_abort && !ovf) begin
        for (int i = 0; i < int'(wr.count); i++) begin
          pending_q.push_back(wr.data[i]);
        end
      end
      // Drop or abort throws the open packet away, commit includes this beat
      if (ovf || (in_pkt && is_abort)) begin
        pending_q.delete();
      end else if (in_pkt && cmd == ring_pkg::CMD_COMMIT) begin
        foreach (pending_q[i]) begin
          committed_q.push_back(pending_q[i]);
        end
        pending_q.delete();
      end
      if (cmd == ring_pkg::CMD_FLUSH) begin
        committed_q.delete();
      end
      if (ovf) begin
        drops++;
      end
      if (cmd == ring_pkg::CMD_COMMIT || is_abort) begin
        st_model = ring_pkg::ST_IDLE;
      end else if (ovf) begin
        st_model = ring_pkg::ST_DROP;
      end else if (wr.valid && in_pkt) begin
        st_model = ring_pkg::ST_OPEN;
      end
      used_model = committed_q.size() + pending_q.size();
      exp_avail  = PTR_W'(committed_q.size());
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  avail_a : assert property (@(posedge clk) disable iff (!rst_n) avail == exp_avail)
    else begin
      errors++;
      $display("MISMATCH %0t avail exp=%0d got=%0d", $time, $sampled(exp_avail),
               $sampled(avail));
    end

  overflow_a : assert property (@(posedge clk) disable iff (!rst_n) overflow == exp_overflow)
    else begin
      errors++;
      $display("MISMATCH %0t overflow exp=%0b got=%0b", $time, $sampled(exp_overflow),
               $sampled(overflow));
    end

  resp_valid_a : assert property (@(posedge clk) disable iff (!rst_n)
    rd_resp.valid == exp_valid)
    else begin
      errors++;
      $display("MISMATCH %0t rd_resp.valid exp=%0b got=%0b", $time, $sampled(exp_valid),
               $sampled(rd_resp.valid));
    end

  resp_count_a : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> rd_resp.count == exp_count)
    else begin
      errors++;
      $display("MISMATCH %0t rd_resp.count exp=%0d got=%0d", $time, $sampled(exp_count),
               $sampled(rd_resp.count));
    end

  // Lane 1 only matters on a two-word grant
  resp_lane0_a : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> rd_resp.data[0] == exp_data[0])
    else begin
      errors++;
      $display("MISMATCH %0t rd_resp.data[0] exp=%02h got=%02h", $time,
               $sampled(exp_data[0]), $sampled(rd_resp.data[0]));
    end

  resp_lane1_a : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid && exp_count == 2 |-> rd_resp.data[1] == exp_data[1])
    else begin
      errors++;
      $display("MISMATCH %0t rd_resp.data[1] exp=%02h got=%02h", $time,
               $sampled(exp_data[1]), $sampled(rd_resp.data[1]));
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic drive_cycle(input bit wv, input int wc, input ring_pkg::cmd_e c,
                             input bit rv, input int rc);
    @(posedge clk);
    #1;
    wr.valid   = wv;
    wr.count   = CNT_W'(wc);
    wr.data[0] = DATA_W'($urandom);
    wr.data[1] = DATA_W'($urandom);
    cmd        = c;
    rd.valid   = rv;
    rd.count   = CNT_W'(rc);
  endtask

  task automatic random_cycle(input int wr_pct, input int rd_pct);
    int r;
    ring_pkg::cmd_e c;
    r = $urandom_range(99);
    if (r < 15) begin
      c = ring_pkg::CMD_COMMIT;
    end else if (r < 20) begin
      c = ring_pkg::CMD_ABORT;
    end else if (r < 22) begin
      c = ring_pkg::CMD_FLUSH;
    end else begin
      c = ring_pkg::CMD_NONE;
    end
    drive_cycle($urandom_range(99) < wr_pct, $urandom_range(1, 2), c,
                $urandom_range(99) < rd_pct, $urandom_range(0, 2));
  endtask

  initial begin
    void'($urandom(20432));
    errors     = 0;
    drops      = 0;
    words_read = 0;
    rst_n      = 1'b0;
    wr         = '0;
    cmd        = ring_pkg::CMD_NONE;
    rd         = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b0, 0);
    // Commit together with a beat, then a grant cut to avail
    drive_cycle(1'b1, 2, ring_pkg::CMD_NONE, 1'b0, 0);
    drive_cycle(1'b1, 1, ring_pkg::CMD_COMMIT, 1'b0, 0);
    drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b1, 2);
    drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b1, 2);
    // Abort with a beat in the same cycle
    drive_cycle(1'b1, 2, ring_pkg::CMD_NONE, 1'b0, 0);
    drive_cycle(1'b1, 2, ring_pkg::CMD_ABORT, 1'b0, 0);
    drive_cycle(1'b1, 1, ring_pkg::CMD_COMMIT, 1'b0, 0);
    drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b1, 2);
    // Six two-word beats overrun the 11 free slots, the seventh is ignored
    repeat (7) drive_cycle(1'b1, 2, ring_pkg::CMD_NONE, 1'b0, 0);
    drive_cycle(1'b0, 0, ring_pkg::CMD_COMMIT, 1'b0, 0);
    drive_cycle(1'b1, 1, ring_pkg::CMD_COMMIT, 1'b0, 0);
    drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b1, 2);
    // Flush with a read in the same cycle
    drive_cycle(1'b1, 2, ring_pkg::CMD_COMMIT, 1'b0, 0);
    drive_cycle(1'b0, 0, ring_pkg::CMD_FLUSH, 1'b1, 2);
    drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b1, 2);
    // Producer heavy, balanced, then consumer heavy
    repeat (PHASE_CYCLES) random_cycle(80, 20);
    repeat (PHASE_CYCLES) random_cycle(50, 50);
    repeat (PHASE_CYCLES) random_cycle(30, 90);
    repeat (4) drive_cycle(1'b0, 0, ring_pkg::CMD_NONE, 1'b0, 0);
    $display("Summary: %0d errors, %0d dropped packets, %0d words read",
             errors, drops, words_read);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb.f
rtl/ring_pkg.sv
rtl/counter_incr.sv
rtl/ring_ctrl.sv
rtl/ring_ptrs.sv
rtl/ring_store.sv
rtl/ring_top.sv
tb/tb_ring.sv

//--- Makefile
# Verilator build and run of the staging ring testbench

run: obj_dir/Vtb_ring
	./obj_dir/Vtb_ring | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_ring: tb.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ring -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
